// ==== include/scope_params.svh ====
//------------------------------
// widths, buffer size, register map, trigger source codes
// and reset values for the capture engine
//------------------------------
`ifndef SCOPE_PARAMS_SVH
`define SCOPE_PARAMS_SVH

`define SCOPE_DW          14             // adc sample width
`define SCOPE_AW          8              // 256 entries per channel
`define SCOPE_SUMW        32             // window accumulator
`define SCOPE_DECW        17
`define SCOPE_SHW         5
`define SCOPE_BUSW        32

// ------------------------------
// register offsets, address bits 19:0
`define SCOPE_REG_CTRL    20'h00000
`define SCOPE_REG_TRIG    20'h00004
`define SCOPE_REG_THR_A   20'h00008
`define SCOPE_REG_THR_B   20'h0000C
`define SCOPE_REG_DLY     20'h00010
`define SCOPE_REG_DEC     20'h00014
`define SCOPE_REG_WP_CUR  20'h00018
`define SCOPE_REG_WP_TRIG 20'h0001C
`define SCOPE_REG_HYST_A  20'h00020
`define SCOPE_REG_HYST_B  20'h00024
`define SCOPE_REG_AVG     20'h00028
`define SCOPE_REG_SHIFT   20'h00098

`define SCOPE_BUF_A       4'h1           // address bits 19:16
`define SCOPE_BUF_B       4'h2

// ------------------------------
// trigger source codes
`define SCOPE_SRC_NONE    4'd0
`define SCOPE_SRC_SW      4'd1
`define SCOPE_SRC_A_RISE  4'd2
`define SCOPE_SRC_A_FALL  4'd3
`define SCOPE_SRC_B_RISE  4'd4
`define SCOPE_SRC_B_FALL  4'd5

`define SCOPE_RST_THR_A   14'sd5000
`define SCOPE_RST_THR_B   (-14'sd5000)
`define SCOPE_RST_HYST    14'sd20
`define SCOPE_RST_DEC     17'd1
`define SCOPE_RST_AVG     1'b1
`define SCOPE_RST_SHIFT   5'd0
`define SCOPE_RST_DLY     32'd0

`define SCOPE_RD_LAT      4              // buffer read ack delay

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the capture engine testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_scope -f vlog.f -o tb_scope
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_scope)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
   exit 0
fi
exit 1

// ==== src/scope_capture.sv ====
//------------------------------
// arm/trigger/post-delay control, write pointers
// and the two-channel sample buffer with read port
//------------------------------
`timescale 1ns/10ps
`include "scope_params.svh"

module scope_capture (
   input  logic                    adc_clk_i,
   input  logic                    adc_rstn_i,
   input  scope_pkg::sample_pair_t smp_i,
   input  logic                    smp_vld_i,
   input  scope_pkg::scope_cfg_t   cfg_i,
   input  scope_pkg::scope_cmd_t   cmd_i,
   input  logic                    trig_i,
   input  scope_pkg::bus_req_t     bus_req_i,
   output scope_pkg::sample_t      rd_a_o,
   output scope_pkg::sample_t      rd_b_o,
   output scope_pkg::scope_stat_t  stat_o,
   output logic                    done_o
);
   import scope_pkg::*;

   sample_t              buf_a [2**`SCOPE_AW];
   sample_t              buf_b [2**`SCOPE_AW];
   logic [`SCOPE_AW-1:0] wp;                       // next entry to write
   logic [`SCOPE_AW-1:0] wp_last;
   logic [`SCOPE_AW-1:0] wp_trig;
   logic [`SCOPE_AW-1:0] raddr_q;
   logic [`SCOPE_AW-1:0] raddr_qq;
   logic [31:0]          dly_cnt;
   logic                 armed;
   logic                 dly_do;                   // trigger seen, counting
   logic                 stop;
   logic                 wr_en;
   logic                 trig_take;

   assign stop      = dly_do && (dly_cnt == 32'd0);
   assign wr_en     = armed && smp_vld_i && !stop;
   assign trig_take = armed && trig_i && !dly_do;  // first trigger only
   assign wp_last   = wp - `SCOPE_AW'(1);

   // ------------------------------
   // capture control
   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         armed   <= 1'b0;
         dly_do  <= 1'b0;
         wp      <= '0;
         wp_trig <= '0;
         dly_cnt <= '0;
      end else begin
         if (cmd_i.arm)
            armed <= 1'b1;
         else if (cmd_i.clr || (stop && !cfg_i.keep))
            armed <= 1'b0;

         if (cmd_i.arm || cmd_i.clr || stop)
            dly_do <= 1'b0;
         else if (trig_take)
            dly_do <= 1'b1;

         if (cmd_i.clr)
            wp <= '0;
         else if (wr_en)
            wp <= wp + `SCOPE_AW'(1);

         if (cmd_i.clr)
            wp_trig <= '0;
         else if (trig_take)
            wp_trig <= wr_en ? wp : wp_last;       // entry holding the trigger sample

         if (trig_take)
            dly_cnt <= cfg_i.dly;
         else if (dly_do && wr_en)
            dly_cnt <= dly_cnt - 32'd1;
      end
   end

   // ------------------------------
   // sample buffer
   always_ff @(posedge adc_clk_i) begin
      if (wr_en) begin
         buf_a[wp] <= smp_i.a;
         buf_b[wp] <= smp_i.b;
      end
   end

   // address registered twice before the ram read
   always_ff @(posedge adc_clk_i) begin
      raddr_q  <= bus_req_i.addr[`SCOPE_AW+1:2];
      raddr_qq <= raddr_q;
      rd_a_o   <= buf_a[raddr_qq];
      rd_b_o   <= buf_b[raddr_qq];
   end

   assign stat_o = '{armed: armed, trig_pend: dly_do, wp: wp_last, wp_trig: wp_trig};
   assign done_o = stop;

endmodule

// ==== src/scope_decimator.sv ====
//------------------------------
// window summing and shift averaging per channel
//------------------------------
`timescale 1ns/10ps
`include "scope_params.svh"

module scope_decimator (
   input  logic                    adc_clk_i,
   input  logic                    adc_rstn_i,
   input  scope_pkg::sample_t      adc_a_i,
   input  scope_pkg::sample_t      adc_b_i,
   input  scope_pkg::scope_cfg_t   cfg_i,
   input  logic                    arm_i,
   output scope_pkg::sample_pair_t smp_o,
   output logic                    smp_vld_o
);
   import scope_pkg::*;

   logic signed [`SCOPE_SUMW-1:0] sum_a;
   logic signed [`SCOPE_SUMW-1:0] sum_b;
   logic [`SCOPE_DECW-1:0]        dec_cnt;
   logic                          win_done;

   assign win_done = (dec_cnt >= cfg_i.dec);

   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         dec_cnt   <= '0;
         sum_a     <= '0;
         sum_b     <= '0;
         smp_vld_o <= 1'b0;
      end else begin
         if (win_done || arm_i) begin                // new window
            dec_cnt <= `SCOPE_DECW'(1);
            sum_a   <= `SCOPE_SUMW'(adc_a_i);
            sum_b   <= `SCOPE_SUMW'(adc_b_i);
         end else begin
            dec_cnt <= dec_cnt + `SCOPE_DECW'(1);
            sum_a   <= sum_a + `SCOPE_SUMW'(adc_a_i);
            sum_b   <= sum_b + `SCOPE_SUMW'(adc_b_i);
         end
         smp_vld_o <= win_done;                      // once per window
      end
   end

   // output sample, registered with the valid
   always_ff @(posedge adc_clk_i) begin
      if (cfg_i.avg_en) begin
         smp_o.a <= sample_t'(sum_a >>> cfg_i.shift);
         smp_o.b <= sample_t'(sum_b >>> cfg_i.shift);
      end else begin
         smp_o.a <= adc_a_i;                         // raw, each from its own channel
         smp_o.b <= adc_b_i;
      end
   end

endmodule

// ==== src/scope_pkg.sv ====
//------------------------------
// shared types: samples, bus request/response,
// configuration, commands and status
//------------------------------
`include "scope_params.svh"

package scope_pkg;

   typedef logic signed [`SCOPE_DW-1:0] sample_t;

   typedef struct packed {
      sample_t a;
      sample_t b;
   } sample_pair_t;

   typedef struct packed {
      logic [`SCOPE_BUSW-1:0] addr;
      logic [`SCOPE_BUSW-1:0] wdata;
      logic                   wen;        // one-cycle strobes
      logic                   ren;
   } bus_req_t;

   typedef struct packed {
      logic [`SCOPE_BUSW-1:0] rdata;
      logic                   ack;
   } bus_rsp_t;

   typedef struct packed {
      sample_t                thr_a;
      sample_t                thr_b;
      sample_t                hyst_a;
      sample_t                hyst_b;
      logic [`SCOPE_DECW-1:0] dec;
      logic [`SCOPE_SHW-1:0]  shift;
      logic                   avg_en;
      logic [31:0]            dly;        // post-trigger samples
      logic                   keep;       // stay armed after capture
      logic [3:0]             src;
   } scope_cfg_t;

   typedef struct packed {
      logic arm;
      logic clr;
      logic sw_trig;
   } scope_cmd_t;

   typedef struct packed {
      logic                 armed;
      logic                 trig_pend;
      logic [`SCOPE_AW-1:0] wp;           // last written entry
      logic [`SCOPE_AW-1:0] wp_trig;
   } scope_stat_t;

endpackage

// ==== src/scope_regs.sv ====
//------------------------------
// register decode, config and command registers,
// readback and bus ack timing
//------------------------------
`timescale 1ns/10ps
`include "scope_params.svh"

module scope_regs (
   input  logic                   adc_clk_i,
   input  logic                   adc_rstn_i,
   input  scope_pkg::bus_req_t    bus_req_i,
   input  scope_pkg::scope_stat_t stat_i,
   input  logic                   done_i,
   input  scope_pkg::sample_t     rd_a_i,
   input  scope_pkg::sample_t     rd_b_i,
   output scope_pkg::scope_cfg_t  cfg_o,
   output scope_pkg::scope_cmd_t  cmd_o,
   output scope_pkg::bus_rsp_t    bus_rsp_o
);
   import scope_pkg::*;

   logic [19:0]              reg_off;
   logic [3:0]               region;
   logic                     buf_sel;
   logic [`SCOPE_BUSW-1:0]   wdata;
   logic [`SCOPE_BUSW-1:0]   reg_rdata;
   logic [`SCOPE_BUSW-1:0]   buf_rdata;
   logic [`SCOPE_BUSW-1:0]   rdata_q;
   logic [`SCOPE_RD_LAT-2:0] rd_pipe;              // buffer read in flight
   logic                     ack_q;
   scope_cfg_t               cfg_q;
   scope_cmd_t               cmd_q;

   assign reg_off = bus_req_i.addr[19:0];
   assign region  = reg_off[19:16];
   assign buf_sel = (region == `SCOPE_BUF_A) || (region == `SCOPE_BUF_B);
   assign wdata   = bus_req_i.wdata;

   // ------------------------------
   // configuration
   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         cfg_q <= '{thr_a: `SCOPE_RST_THR_A, thr_b: `SCOPE_RST_THR_B,
                    hyst_a: `SCOPE_RST_HYST, hyst_b: `SCOPE_RST_HYST,
                    dec: `SCOPE_RST_DEC, shift: `SCOPE_RST_SHIFT,
                    avg_en: `SCOPE_RST_AVG, dly: `SCOPE_RST_DLY,
                    keep: 1'b0, src: `SCOPE_SRC_NONE};
      end else begin
         if (bus_req_i.wen) begin
            case (reg_off)
               `SCOPE_REG_CTRL:   cfg_q.keep   <= wdata[3];
               `SCOPE_REG_THR_A:  cfg_q.thr_a  <= wdata[`SCOPE_DW-1:0];
               `SCOPE_REG_THR_B:  cfg_q.thr_b  <= wdata[`SCOPE_DW-1:0];
               `SCOPE_REG_DLY:    cfg_q.dly    <= wdata;
               `SCOPE_REG_DEC:    cfg_q.dec    <= wdata[`SCOPE_DECW-1:0];
               `SCOPE_REG_HYST_A: cfg_q.hyst_a <= wdata[`SCOPE_DW-1:0];
               `SCOPE_REG_HYST_B: cfg_q.hyst_b <= wdata[`SCOPE_DW-1:0];
               `SCOPE_REG_AVG:    cfg_q.avg_en <= wdata[0];
               `SCOPE_REG_SHIFT:  cfg_q.shift  <= wdata[`SCOPE_SHW-1:0];
               default: ;
            endcase
         end
         if (bus_req_i.wen && (reg_off == `SCOPE_REG_TRIG))
            cfg_q.src <= wdata[3:0];
         else if (done_i || cmd_q.clr)
            cfg_q.src <= `SCOPE_SRC_NONE;          // one shot per capture
      end
   end

   // command pulses, one cycle after the write
   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         cmd_q <= '0;
      end else begin
         cmd_q.arm     <= bus_req_i.wen && (reg_off == `SCOPE_REG_CTRL) && wdata[0];
         cmd_q.clr     <= bus_req_i.wen && (reg_off == `SCOPE_REG_CTRL) && wdata[1];
         cmd_q.sw_trig <= bus_req_i.wen && (reg_off == `SCOPE_REG_TRIG) &&
                          (wdata[3:0] == `SCOPE_SRC_SW);
      end
   end

   // ------------------------------
   // readback
   always_comb begin
      reg_rdata = '0;                              // unmapped reads zero
      case (reg_off)
         `SCOPE_REG_CTRL:    reg_rdata[3:0] = {cfg_q.keep, stat_i.trig_pend,
                                               1'b0, stat_i.armed};
         `SCOPE_REG_TRIG:    reg_rdata[3:0] = cfg_q.src;
         `SCOPE_REG_THR_A:   reg_rdata = `SCOPE_BUSW'(cfg_q.thr_a);
         `SCOPE_REG_THR_B:   reg_rdata = `SCOPE_BUSW'(cfg_q.thr_b);
         `SCOPE_REG_DLY:     reg_rdata = cfg_q.dly;
         `SCOPE_REG_DEC:     reg_rdata[`SCOPE_DECW-1:0] = cfg_q.dec;
         `SCOPE_REG_WP_CUR:  reg_rdata[`SCOPE_AW-1:0] = stat_i.wp;
         `SCOPE_REG_WP_TRIG: reg_rdata[`SCOPE_AW-1:0] = stat_i.wp_trig;
         `SCOPE_REG_HYST_A:  reg_rdata = `SCOPE_BUSW'(cfg_q.hyst_a);
         `SCOPE_REG_HYST_B:  reg_rdata = `SCOPE_BUSW'(cfg_q.hyst_b);
         `SCOPE_REG_AVG:     reg_rdata[0] = cfg_q.avg_en;
         `SCOPE_REG_SHIFT:   reg_rdata[`SCOPE_SHW-1:0] = cfg_q.shift;
         default: ;
      endcase
   end

   assign buf_rdata = `SCOPE_BUSW'((region == `SCOPE_BUF_B) ? rd_b_i : rd_a_i);

   // register ack after 1 cycle, buffer ack after SCOPE_RD_LAT
   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         rd_pipe <= '0;
         ack_q   <= 1'b0;
      end else begin
         rd_pipe <= {rd_pipe[`SCOPE_RD_LAT-3:0], bus_req_i.ren && buf_sel};
         ack_q   <= (bus_req_i.wen || (bus_req_i.ren && !buf_sel)) ||
                    rd_pipe[`SCOPE_RD_LAT-2];
      end
   end

   always_ff @(posedge adc_clk_i) begin
      rdata_q <= rd_pipe[`SCOPE_RD_LAT-2] ? buf_rdata : reg_rdata;
   end

   assign cfg_o     = cfg_q;
   assign cmd_o     = cmd_q;
   assign bus_rsp_o = '{rdata: rdata_q, ack: ack_q};

endmodule

// ==== src/scope_top.sv ====
//------------------------------
// two-channel capture engine top level
//------------------------------
`timescale 1ns/10ps
`include "scope_params.svh"

module scope_top (
   input  logic                adc_clk_i,
   input  logic                adc_rstn_i,
   input  scope_pkg::sample_t  adc_a_i,
   input  scope_pkg::sample_t  adc_b_i,
   input  scope_pkg::bus_req_t bus_req_i,
   output scope_pkg::bus_rsp_t bus_rsp_o
);
   import scope_pkg::*;

   scope_cfg_t   cfg;
   scope_cmd_t   cmd;
   sample_pair_t smp;
   logic         smp_vld;
   logic         trig;
   scope_stat_t  stat;
   logic         done;                             // capture finished
   sample_t      rd_a;
   sample_t      rd_b;

   scope_decimator u_dec (
      .adc_clk_i  (adc_clk_i),
      .adc_rstn_i (adc_rstn_i),
      .adc_a_i    (adc_a_i),
      .adc_b_i    (adc_b_i),
      .cfg_i      (cfg),
      .arm_i      (cmd.arm),
      .smp_o      (smp),
      .smp_vld_o  (smp_vld)
   );

   scope_trigger u_trig (
      .adc_clk_i  (adc_clk_i),
      .adc_rstn_i (adc_rstn_i),
      .smp_i      (smp),
      .smp_vld_i  (smp_vld),
      .cfg_i      (cfg),
      .sw_trig_i  (cmd.sw_trig),
      .trig_o     (trig)
   );

   scope_capture u_cap (
      .adc_clk_i  (adc_clk_i),
      .adc_rstn_i (adc_rstn_i),
      .smp_i      (smp),
      .smp_vld_i  (smp_vld),
      .cfg_i      (cfg),
      .cmd_i      (cmd),
      .trig_i     (trig),
      .bus_req_i  (bus_req_i),
      .rd_a_o     (rd_a),
      .rd_b_o     (rd_b),
      .stat_o     (stat),
      .done_o     (done)
   );

   scope_regs u_regs (
      .adc_clk_i  (adc_clk_i),
      .adc_rstn_i (adc_rstn_i),
      .bus_req_i  (bus_req_i),
      .stat_i     (stat),
      .done_i     (done),
      .rd_a_i     (rd_a),
      .rd_b_i     (rd_b),
      .cfg_o      (cfg),
      .cmd_o      (cmd),
      .bus_rsp_o  (bus_rsp_o)
   );

endmodule

// ==== src/scope_trigger.sv ====
//------------------------------
// schmitt comparators, edge pulses, source select
//------------------------------
`timescale 1ns/10ps
`include "scope_params.svh"

module scope_trigger (
   input  logic                    adc_clk_i,
   input  logic                    adc_rstn_i,
   input  scope_pkg::sample_pair_t smp_i,
   input  logic                    smp_vld_i,
   input  scope_pkg::scope_cfg_t   cfg_i,
   input  logic                    sw_trig_i,
   output logic                    trig_o
);
   import scope_pkg::*;

   sample_t                   smp_ch [2];
   sample_t                   thr_ch [2];
   sample_t                   hys_ch [2];
   logic signed [`SCOPE_DW:0] lim_lo [2];        // one bit wider, no overflow
   logic signed [`SCOPE_DW:0] lim_hi [2];
   logic [3:0]                sch_q;             // {b_fall, b_rise, a_fall, a_rise}
   logic [3:0]                sch_d;
   logic [3:0]                edge_q;

   assign smp_ch[0] = smp_i.a;
   assign smp_ch[1] = smp_i.b;
   assign thr_ch[0] = cfg_i.thr_a;
   assign thr_ch[1] = cfg_i.thr_b;
   assign hys_ch[0] = cfg_i.hyst_a;
   assign hys_ch[1] = cfg_i.hyst_b;

   // hysteresis limits follow the config one cycle late
   always_ff @(posedge adc_clk_i) begin
      for (int ch = 0; ch < 2; ch++) begin
         lim_lo[ch] <= thr_ch[ch] - hys_ch[ch];
         lim_hi[ch] <= thr_ch[ch] + hys_ch[ch];
      end
   end

   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         sch_q  <= '0;
         sch_d  <= '0;
         edge_q <= '0;
         trig_o <= 1'b0;
      end else begin
         if (smp_vld_i) begin
            for (int ch = 0; ch < 2; ch++) begin
               if (smp_ch[ch] >= thr_ch[ch])
                  sch_q[2*ch] <= 1'b1;               // rising, reached
               else if (smp_ch[ch] < lim_lo[ch])
                  sch_q[2*ch] <= 1'b0;               // rearm below hysteresis
               if (smp_ch[ch] <= thr_ch[ch])
                  sch_q[2*ch+1] <= 1'b1;             // falling, reached
               else if (smp_ch[ch] > lim_hi[ch])
                  sch_q[2*ch+1] <= 1'b0;
            end
         end
         sch_d  <= sch_q;
         edge_q <= sch_q & ~sch_d;                   // one-cycle set pulses

         case (cfg_i.src)
            `SCOPE_SRC_SW:     trig_o <= sw_trig_i;
            `SCOPE_SRC_A_RISE: trig_o <= edge_q[0];
            `SCOPE_SRC_A_FALL: trig_o <= edge_q[1];
            `SCOPE_SRC_B_RISE: trig_o <= edge_q[2];
            `SCOPE_SRC_B_FALL: trig_o <= edge_q[3];
            default:           trig_o <= 1'b0;       // none or unknown
         endcase
      end
   end

endmodule

// ==== tests/tb_scope.sv ====
//------------------------------
// testbench for the capture engine: bus tasks, ramp stimulus,
// register model, capture and trigger checks
//------------------------------
`timescale 1ns/10ps
`include "scope_params.svh"

module tb_scope;
   import scope_pkg::*;

   logic     adc_clk;
   logic     adc_rstn;
   sample_t  adc_a;
   sample_t  adc_b;
   bus_req_t bus_req;
   bus_rsp_t bus_rsp;
   sample_t  win_a [16];                             // buffer window, oldest first
   sample_t  win_b [16];
   int       errors    = 0;
   int       checks    = 0;
   int       tests     = 0;
   int       test_err  = 0;
   bit       timed_out = 1'b0;
   int       ramp_base = 0;
   int       ramp_step = 0;
   int       ramp_gen  = 0;

   scope_top UUT (
      .adc_clk_i  (adc_clk),
      .adc_rstn_i (adc_rstn),
      .adc_a_i    (adc_a),
      .adc_b_i    (adc_b),
      .bus_req_i  (bus_req),
      .bus_rsp_o  (bus_rsp)
   );

   initial begin
      adc_clk = 1'b0;
      forever #2 adc_clk = ~adc_clk;
   end

   // ramp source, B is always the negative of A
   initial begin
      int gen_seen;
      int val;
      gen_seen = 0;
      val      = 0;
      adc_a    = '0;
      adc_b    = '0;
      forever begin
         @(negedge adc_clk);
         if (ramp_gen != gen_seen) begin
            gen_seen = ramp_gen;                     // new start value
            val      = ramp_base;
         end else begin
            val = val + ramp_step;
         end
         adc_a = sample_t'(val);
         adc_b = sample_t'(-val);
      end
   end

   initial begin
      wait (timed_out);
      $display("TB FAILED");
      $finish;
   end

   // ------------------------------
   // helpers
   task automatic set_ramp(input int base, input int step);
      @(posedge adc_clk);                            // picked up on the next falling edge
      ramp_base = base;
      ramp_step = step;
      ramp_gen  = ramp_gen + 1;
   endtask

   task automatic idle(input int n);
      repeat (n) @(negedge adc_clk);
   endtask

   task automatic park_on_timeout(input string what);
      $display("timeout while waiting for %s", what);
      timed_out = 1'b1;
      forever @(negedge adc_clk);                    // watcher ends the run
   endtask

   task automatic bus_access(input logic [19:0] off, input logic [31:0] wdata,
                             input logic wr, output logic [31:0] rdata);
      int n;
      int lat;
      lat = (!wr && (off[19:16] == `SCOPE_BUF_A || off[19:16] == `SCOPE_BUF_B)) ?
            `SCOPE_RD_LAT : 1;                       // buffer reads go through the ram pipe
      @(negedge adc_clk);
      bus_req = '{addr: {12'h0, off}, wdata: wdata, wen: wr, ren: !wr};
      @(negedge adc_clk);
      bus_req.wen = 1'b0;                            // strobe for one cycle only
      bus_req.ren = 1'b0;
      n = 0;
      while (!bus_rsp.ack && n < 20) begin
         @(negedge adc_clk);
         n++;
      end
      if (!bus_rsp.ack)
         park_on_timeout($sformatf("bus ack at offset 0x%05h", off));
      compare($sformatf("ack latency at 0x%05h", off), n + 1, lat);
      rdata = bus_rsp.rdata;
   endtask

   task automatic bus_write(input logic [19:0] off, input logic [31:0] wdata);
      logic [31:0] rdata;
      bus_access(off, wdata, 1'b1, rdata);
   endtask

   task automatic bus_read(input logic [19:0] off, output logic [31:0] rdata);
      bus_access(off, 32'h0, 1'b0, rdata);
   endtask

   task automatic wait_disarmed(input int limit);
      logic [31:0] ctrl;
      int          n;
      n = 0;
      bus_read(`SCOPE_REG_CTRL, ctrl);
      while (ctrl[0] && n < limit) begin
         bus_read(`SCOPE_REG_CTRL, ctrl);
         n++;
      end
      if (ctrl[0])
         park_on_timeout("armed to clear after the trigger");
   endtask

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("error %s: got 0x%08h, expected 0x%08h", name, got, exp);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors == test_err)
         $display("test %0d %s: ok", tests, name);
      else
         $display("test %0d %s: %0d errors", tests, name, errors - test_err);
      test_err = errors;
   endtask

   // register model, each field keeps only its own width
   function automatic logic [31:0] reg_model(input logic [19:0] off, input logic [31:0] w);
      case (off)
         `SCOPE_REG_THR_A, `SCOPE_REG_THR_B,
         `SCOPE_REG_HYST_A, `SCOPE_REG_HYST_B: return {{18{w[13]}}, w[13:0]};
         `SCOPE_REG_DEC:   return {15'd0, w[16:0]};
         `SCOPE_REG_SHIFT: return {27'd0, w[4:0]};
         `SCOPE_REG_AVG:   return {31'd0, w[0]};
         default:          return w;
      endcase
   endfunction

   task automatic run_sw_capture(input int pre);
      bus_write(`SCOPE_REG_CTRL, 32'h1);             // arm
      idle(pre);                                     // fill entries ahead of the trigger
      bus_write(`SCOPE_REG_TRIG, {28'h0, `SCOPE_SRC_SW});
      wait_disarmed(500);
   endtask

   task automatic read_window(input logic [7:0] last);
      logic [31:0] d;
      logic [7:0]  idx;
      for (int k = 0; k < 16; k++) begin
         idx = last - 8'(15 - k);
         bus_read({`SCOPE_BUF_A, 6'h0, idx, 2'b00}, d);
         win_a[k] = sample_t'(d[`SCOPE_DW-1:0]);
         bus_read({`SCOPE_BUF_B, 6'h0, idx, 2'b00}, d);
         win_b[k] = sample_t'(d[`SCOPE_DW-1:0]);
      end
   endtask

   task automatic check_steps(input int step, input int b_off);
      for (int k = 1; k < 16; k++)
         compare($sformatf("buf_a[%0d] step", k), int'(win_a[k]) - int'(win_a[k-1]), step);
      for (int k = 0; k < 16; k++)
         compare($sformatf("buf_b[%0d]", k), 32'(win_b[k]), 32'(-int'(win_a[k]) - b_off));
   endtask

   // ------------------------------
   // tests
   task automatic check_registers();
      logic [19:0] offs [8];
      logic [31:0] wv [8];
      logic [31:0] d;
      offs = '{`SCOPE_REG_THR_A, `SCOPE_REG_THR_B, `SCOPE_REG_HYST_A, `SCOPE_REG_HYST_B,
               `SCOPE_REG_DEC, `SCOPE_REG_SHIFT, `SCOPE_REG_AVG, `SCOPE_REG_DLY};
      for (int i = 0; i < 8; i++) begin
         wv[i] = $urandom;
         bus_write(offs[i], wv[i]);
      end
      for (int i = 0; i < 8; i++) begin
         bus_read(offs[i], d);
         compare($sformatf("reg 0x%05h", offs[i]), d, reg_model(offs[i], wv[i]));
      end
      bus_read(20'h00040, d);
      compare("unmapped 0x00040", d, 32'h0);
      end_test("register readback");
   endtask

   task automatic check_capture(input logic avg, input int dec, input int pre, input int step);
      logic [31:0] d;
      bus_write(`SCOPE_REG_AVG, {31'h0, avg});
      bus_write(`SCOPE_REG_DEC, 32'(dec));
      bus_write(`SCOPE_REG_SHIFT, 32'h2);            // used only with averaging on
      bus_write(`SCOPE_REG_DLY, 32'h0);
      set_ramp(-2000 - int'($urandom % 1000), 1);
      run_sw_capture(pre);
      bus_read(`SCOPE_REG_WP_TRIG, d);
      read_window(d[7:0]);
      check_steps(step, int'(avg));                  // floored shift of -sum sits one below -a
      end_test(avg ? "averaged capture" : "raw capture");
   endtask

   task automatic check_post_delay();
      logic [31:0] cur;
      logic [31:0] trg;
      int          dly;
      dly = 1 + int'($urandom % 100);
      bus_write(`SCOPE_REG_AVG, 32'h0);
      bus_write(`SCOPE_REG_DEC, 32'h1);
      bus_write(`SCOPE_REG_DLY, 32'(dly));
      set_ramp(-2000 - int'($urandom % 1000), 1);
      run_sw_capture(20);
      bus_read(`SCOPE_REG_WP_CUR, cur);
      bus_read(`SCOPE_REG_WP_TRIG, trg);
      compare("wp_cur - wp_trig", {24'h0, cur[7:0] - trg[7:0]}, 32'(dly % 256));
      end_test("post-trigger delay");
   endtask

   task automatic check_schmitt_trigger();
      logic [31:0] d;
      int          thr;
      int          hyst;
      thr  = int'($urandom % 4001) - 2000;
      hyst = 20 + int'($urandom % 50);
      bus_write(`SCOPE_REG_DLY, 32'h0);
      bus_write(`SCOPE_REG_THR_A, 32'(thr));
      bus_write(`SCOPE_REG_HYST_A, 32'(hyst));
      set_ramp(thr - hyst - 40, 0);                  // held below the lower limit
      idle(10);
      bus_write(`SCOPE_REG_TRIG, {28'h0, `SCOPE_SRC_A_RISE});
      bus_write(`SCOPE_REG_CTRL, 32'h1);
      idle(30);
      bus_read(`SCOPE_REG_CTRL, d);
      compare("ctrl armed while held low", {31'h0, d[0]}, 32'h1);
      set_ramp(thr - hyst - 40, 1);                  // now ramp through the threshold
      wait_disarmed(500);
      bus_read(`SCOPE_REG_TRIG, d);
      compare("trig source after capture", d, 32'h0);
      end_test("schmitt trigger on A rising");
   endtask

   initial begin
      adc_rstn = 1'b0;
      bus_req  = '0;
      void'($urandom(32'h8ea7be52));
      repeat (10) @(negedge adc_clk);
      adc_rstn = 1'b1;
      idle(5);
      check_registers();
      check_capture(1'b0, 1, 40, 1);
      check_capture(1'b1, 4, 120, 4);
      check_post_delay();
      check_schmitt_trigger();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+include
src/scope_pkg.sv
src/scope_decimator.sv
src/scope_trigger.sv
src/scope_capture.sv
src/scope_regs.sv
src/scope_top.sv
tests/tb_scope.sv
